/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f tb.f --top-module tb_sd_cmd_host -Mdir obj_dir -o sim
	./obj_dir/sim | tee sim.log
	grep -q "^Finished with no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* sd_cmd_controller.sv */
`timescale 1ns/100ps
`default_nettype none

module sd_cmd_controller (
	input  wire logic                       clock,
	input  wire logic                       reset,
	input  wire sd_cmd_pkg::sd_cmd_req_t    cmd_req,
	input  wire logic                       cmd_req_valid,
	output logic                            cmd_req_ready,
	output sd_cmd_pkg::sd_frame_t           tx_frame,
	output logic                            tx_valid,
	input  wire logic                       tx_ready,
	input  wire logic                       tx_done,
	output logic                            rx_enable,
	input  wire logic                       rx_start,
	input  wire logic                       rx_valid,
	input  wire sd_cmd_pkg::sd_frame_t      rx_frame,
	input  wire logic                       rx_crc_ok,
	output sd_cmd_pkg::sd_cmd_result_t      result,
	output logic                            result_valid
);
	import sd_cmd_pkg::*;

	sd_cmd_state_e  state;
	sd_cmd_req_t    req_q;
	logic [31:0]    wait_cnt;
	logic           resp_seen;
	sd_result_e     rx_code;
	logic           finish_now;
	sd_cmd_result_t finish_result;

	assign cmd_req_ready = (state == ST_IDLE);
	assign rx_enable     = (state == ST_WAIT_RESP);
	assign tx_frame      = '{index: req_q.index, payload: req_q.argument};

	// crc failure outranks a wrong index
	always_comb
	begin
		if (!rx_crc_ok)
			rx_code = RES_CRC_ERR;
		else if (rx_frame.index != req_q.index)
			rx_code = RES_INDEX_ERR;
		else
			rx_code = RES_OK;
	end

	always_comb
	begin
		finish_now    = 1'b0;
		finish_result = '{code: RES_OK, response: 32'd0};
		case (state)
			ST_SEND:
				finish_now = tx_done && !req_q.expect_resp;
			ST_WAIT_RESP:
			begin
				if (rx_valid)
				begin
					finish_now         = 1'b1;
					finish_result.code = rx_code;
					if (rx_code == RES_OK)
						finish_result.response = rx_frame.payload;
				end
				else if (!resp_seen && !rx_start && wait_cnt >= req_q.timeout_cycles)
				begin
					finish_now         = 1'b1;
					finish_result.code = RES_TIMEOUT;
				end
			end
			default:
				finish_now = 1'b0;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state        <= ST_IDLE;
			tx_valid     <= 1'b0;
			result_valid <= 1'b0;
			resp_seen    <= 1'b0;
			wait_cnt     <= 32'd0;
		end
		else
		begin
			result_valid <= finish_now;
			case (state)
				ST_IDLE:
				begin
					if (cmd_req_valid)
					begin
						state    <= ST_SEND;
						tx_valid <= 1'b1;
					end
				end
				ST_SEND:
				begin
					if (tx_ready)
						tx_valid <= 1'b0;
					if (finish_now)
						state <= ST_FINISH;
					else if (tx_done)
					begin
						state     <= ST_WAIT_RESP;
						wait_cnt  <= 32'd0;
						resp_seen <= 1'b0;
					end
				end
				ST_WAIT_RESP:
				begin
					if (finish_now)
						state <= ST_FINISH;
					else if (rx_start)
						resp_seen <= 1'b1;
					else if (!resp_seen)
						wait_cnt <= wait_cnt + 32'd1;
				end
				// result_valid is high for this one cycle
				ST_FINISH:
					state <= ST_IDLE;
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (cmd_req_valid && cmd_req_ready)
			req_q <= cmd_req;
		if (finish_now)
			result <= finish_result;
	end

	result_pulse: assert property (@(posedge clock) disable iff (reset)
		result_valid |=> !result_valid);

	// a transfer hands the request just taken to the transceiver
	req_starts_send: assert property (@(posedge clock) disable iff (reset)
		cmd_req_valid && cmd_req_ready |=> state == ST_SEND && tx_valid
			&& tx_frame.index == $past(cmd_req.index)
			&& tx_frame.payload == $past(cmd_req.argument));

endmodule

`default_nettype wire

/* sd_cmd_host.sv */
`timescale 1ns/100ps
`default_nettype none
`include "sd_cmd_macros.svh"

module sd_cmd_host (
	input  wire logic                       clock,
	input  wire logic                       reset,
	input  wire logic [`SD_AXIL_ADDR_W-1:0] s_awaddr,
	input  wire logic                       s_awvalid,
	output logic                            s_awready,
	input  wire logic [31:0]                s_wdata,
	input  wire logic [3:0]                 s_wstrb,
	input  wire logic                       s_wvalid,
	output logic                            s_wready,
	output logic [1:0]                      s_bresp,
	output logic                            s_bvalid,
	input  wire logic                       s_bready,
	input  wire logic [`SD_AXIL_ADDR_W-1:0] s_araddr,
	input  wire logic                       s_arvalid,
	output logic                            s_arready,
	output logic [31:0]                     s_rdata,
	output logic [1:0]                      s_rresp,
	output logic                            s_rvalid,
	input  wire logic                       s_rready,
	output logic                            cmd_out,
	output logic                            cmd_oe,
	input  wire logic                       cmd_in
);
	import sd_cmd_pkg::*;

	sd_cmd_req_t    cmd_req;
	logic           cmd_req_valid;
	logic           cmd_req_ready;
	sd_cmd_result_t result;
	logic           result_valid;
	sd_frame_t      tx_frame;
	logic           tx_valid;
	logic           tx_ready;
	logic           tx_done;
	logic           rx_enable;
	logic           rx_start;
	logic           rx_valid;
	sd_frame_t      rx_frame;
	logic           rx_crc_ok;

	sd_cmd_regs u_regs (
		.clock,
		.reset,
		.s_awaddr,
		.s_awvalid,
		.s_awready,
		.s_wdata,
		.s_wstrb,
		.s_wvalid,
		.s_wready,
		.s_bresp,
		.s_bvalid,
		.s_bready,
		.s_araddr,
		.s_arvalid,
		.s_arready,
		.s_rdata,
		.s_rresp,
		.s_rvalid,
		.s_rready,
		.cmd_req,
		.cmd_req_valid,
		.cmd_req_ready,
		.result,
		.result_valid
	);

	sd_cmd_controller u_controller (
		.clock,
		.reset,
		.cmd_req,
		.cmd_req_valid,
		.cmd_req_ready,
		.tx_frame,
		.tx_valid,
		.tx_ready,
		.tx_done,
		.rx_enable,
		.rx_start,
		.rx_valid,
		.rx_frame,
		.rx_crc_ok,
		.result,
		.result_valid
	);

	sd_cmd_phy u_phy (
		.clock,
		.reset,
		.tx_frame,
		.tx_valid,
		.tx_ready,
		.tx_done,
		.rx_enable,
		.rx_start,
		.rx_valid,
		.rx_frame,
		.rx_crc_ok,
		.cmd_out,
		.cmd_oe,
		.cmd_in
	);

endmodule

`default_nettype wire

/* sd_cmd_macros.svh */
`ifndef SD_CMD_MACROS_SVH
`define SD_CMD_MACROS_SVH

// bits in one command or response frame on the CMD line
// start, transmission, index, argument, crc7 and end bit
`define SD_FRAME_BITS 48

// crc7 generator x^7 + x^3 + 1, top bit implied
`define SD_CRC7_POLY 7'h09

// byte address width of the AXI4-Lite register window
`define SD_AXIL_ADDR_W 5

`endif

/* sd_cmd_phy.sv */
`timescale 1ns/100ps
`default_nettype none
`include "sd_cmd_macros.svh"

module sd_cmd_phy (
	input  wire logic                  clock,
	input  wire logic                  reset,
	input  wire sd_cmd_pkg::sd_frame_t tx_frame,
	input  wire logic                  tx_valid,
	output logic                       tx_ready,
	output logic                       tx_done,
	input  wire logic                  rx_enable,
	output logic                       rx_start,
	output logic                       rx_valid,
	output sd_cmd_pkg::sd_frame_t      rx_frame,
	output logic                       rx_crc_ok,
	output logic                       cmd_out,
	output logic                       cmd_oe,
	input  wire logic                  cmd_in
);
	// crc covers everything ahead of the crc field and end bit
	localparam int         CRC_BITS = `SD_FRAME_BITS - 8;
	localparam logic [5:0] CRC_LAST = 6'(CRC_BITS - 1);
	localparam logic [5:0] LAST_BIT = 6'(`SD_FRAME_BITS - 1);

	logic [`SD_FRAME_BITS-1:0] tx_shift;
	logic [5:0]                tx_cnt;
	logic [6:0]                tx_crc;
	logic [6:0]                tx_crc_next;
	logic                      tx_active;
	logic [`SD_FRAME_BITS-1:0] rx_shift;
	logic [`SD_FRAME_BITS-1:0] rx_word;
	logic [5:0]                rx_cnt;
	logic [6:0]                rx_crc;
	logic                      rx_busy;

	function automatic logic [6:0] crc7_step(input logic [6:0] crc, input logic bit_in);
		logic feedback;
		feedback = bit_in ^ crc[6];
		return {crc[5:0], 1'b0} ^ (feedback ? `SD_CRC7_POLY : 7'd0);
	endfunction

	assign tx_ready    = !tx_active;
	assign cmd_oe      = tx_active;
	assign cmd_out     = tx_active ? tx_shift[`SD_FRAME_BITS-1] : 1'b1;
	assign tx_crc_next = crc7_step(tx_crc, tx_shift[`SD_FRAME_BITS-1]);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			tx_active <= 1'b0;
			tx_done   <= 1'b0;
		end
		else
		begin
			tx_done <= 1'b0;
			if (tx_valid && tx_ready)
				tx_active <= 1'b1;
			else if (tx_active && tx_cnt == LAST_BIT)
			begin
				tx_active <= 1'b0;
				tx_done   <= 1'b1;
			end
		end
	end

	// msb first, crc and end bit replace the tail after bit 39
	always_ff @(posedge clock)
	begin
		if (tx_valid && tx_ready)
		begin
			tx_shift <= {2'b01, tx_frame, 8'h00};
			tx_cnt   <= 6'd0;
			tx_crc   <= 7'd0;
		end
		else if (tx_active)
		begin
			tx_cnt <= tx_cnt + 6'd1;
			tx_crc <= tx_crc_next;
			if (tx_cnt == CRC_LAST)
				tx_shift <= {tx_crc_next, 1'b1, {CRC_BITS{1'b0}}};
			else
				tx_shift <= tx_shift << 1;
		end
	end

	// the last 48 samples of the line, newest in bit 0
	assign rx_word = {rx_shift[`SD_FRAME_BITS-2:0], cmd_in};

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			rx_busy  <= 1'b0;
			rx_start <= 1'b0;
			rx_valid <= 1'b0;
		end
		else
		begin
			rx_start <= 1'b0;
			rx_valid <= 1'b0;
			if (!rx_enable)
				rx_busy <= 1'b0;
			else if (!rx_busy)
			begin
				if (!cmd_in)
				begin
					rx_busy  <= 1'b1;
					rx_start <= 1'b1;
				end
			end
			else if (rx_cnt == LAST_BIT)
			begin
				rx_busy  <= 1'b0;
				rx_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		rx_shift <= rx_word;
		if (!rx_busy)
		begin
			rx_cnt <= 6'd1;
			rx_crc <= crc7_step(7'd0, cmd_in);
		end
		else
		begin
			rx_cnt <= rx_cnt + 6'd1;
			if (rx_cnt <= CRC_LAST)
				rx_crc <= crc7_step(rx_crc, cmd_in);
		end
		if (rx_busy && rx_cnt == LAST_BIT)
		begin
			rx_frame  <= rx_word[`SD_FRAME_BITS-3:8];
			rx_crc_ok <= (rx_crc == rx_word[7:1]);
		end
	end

	// the sequencer only opens the receiver once the frame is out
	no_tx_rx_overlap: assert property (@(posedge clock) disable iff (reset)
		!(cmd_oe && (rx_busy || rx_start || rx_valid)));

endmodule

`default_nettype wire

/* sd_cmd_pkg.sv */
`default_nettype none
`include "sd_cmd_macros.svh"

package sd_cmd_pkg;

	typedef enum logic [`SD_AXIL_ADDR_W-1:0] {
		REG_ARG      = 'h00,
		REG_CMD      = 'h04,
		REG_TIMEOUT  = 'h08,
		REG_STATUS   = 'h0C,
		REG_RESPONSE = 'h10
	} sd_reg_addr_e;

	typedef enum logic [1:0] {
		RES_OK,
		RES_TIMEOUT,
		RES_CRC_ERR,
		RES_INDEX_ERR
	} sd_result_e;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SEND,
		ST_WAIT_RESP,
		ST_FINISH
	} sd_cmd_state_e;

	typedef struct packed {
		logic [5:0]  index;
		logic [31:0] argument;
		logic        expect_resp;
		logic [31:0] timeout_cycles;
	} sd_cmd_req_t;

	// frame body without framing bits and crc
	typedef struct packed {
		logic [5:0]  index;
		logic [31:0] payload;
	} sd_frame_t;

	typedef struct packed {
		sd_result_e  code;
		logic [31:0] response;
	} sd_cmd_result_t;

endpackage

`default_nettype wire

/* sd_cmd_regs.sv */
`timescale 1ns/100ps
`default_nettype none
`include "sd_cmd_macros.svh"

module sd_cmd_regs (
	input  wire logic                       clock,
	input  wire logic                       reset,
	input  wire logic [`SD_AXIL_ADDR_W-1:0] s_awaddr,
	input  wire logic                       s_awvalid,
	output logic                            s_awready,
	input  wire logic [31:0]                s_wdata,
	input  wire logic [3:0]                 s_wstrb,
	input  wire logic                       s_wvalid,
	output logic                            s_wready,
	output logic [1:0]                      s_bresp,
	output logic                            s_bvalid,
	input  wire logic                       s_bready,
	input  wire logic [`SD_AXIL_ADDR_W-1:0] s_araddr,
	input  wire logic                       s_arvalid,
	output logic                            s_arready,
	output logic [31:0]                     s_rdata,
	output logic [1:0]                      s_rresp,
	output logic                            s_rvalid,
	input  wire logic                       s_rready,
	output sd_cmd_pkg::sd_cmd_req_t         cmd_req,
	output logic                            cmd_req_valid,
	input  wire logic                       cmd_req_ready,
	input  wire sd_cmd_pkg::sd_cmd_result_t result,
	input  wire logic                       result_valid
);
	import sd_cmd_pkg::*;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	logic                       aw_got;
	logic                       w_got;
	logic [`SD_AXIL_ADDR_W-1:0] aw_addr_q;
	logic [31:0]                w_data_q;
	logic [3:0]                 w_strb_q;
	logic                       wr_go;
	logic                       wr_err;
	logic [`SD_AXIL_ADDR_W-1:0] wr_addr;
	logic [31:0]                wr_data;
	logic [3:0]                 wr_strb;
	logic [31:0]                rd_data;
	logic                       rd_err;
	logic [31:0]                arg_q;
	logic [31:0]                timeout_q;
	logic                       busy_q;
	logic                       done_q;
	sd_cmd_result_t             result_q;
	logic                       cmd_blocked;
	logic                       cmd_launch;

	function automatic logic [31:0] apply_strb(input logic [31:0] old_val,
			input logic [31:0] new_val, input logic [3:0] strb);
		logic [31:0] merged;
		merged = old_val;
		for (int i = 0; i < 4; i++)
		begin
			if (strb[i])
				merged[8*i +: 8] = new_val[8*i +: 8];
		end
		return merged;
	endfunction

	// address and data may come in either order, held until both are in
	assign s_awready = !aw_got && !s_bvalid;
	assign s_wready  = !w_got && !s_bvalid;
	assign wr_go     = (aw_got || s_awvalid) && (w_got || s_wvalid) && !s_bvalid;
	assign wr_addr   = aw_got ? aw_addr_q : s_awaddr;
	assign wr_data   = w_got ? w_data_q : s_wdata;
	assign wr_strb   = w_got ? w_strb_q : s_wstrb;

	// a pending request counts as busy for a second launch
	assign cmd_blocked = busy_q || cmd_req_valid;
	assign cmd_launch  = wr_go && !wr_err && (sd_reg_addr_e'(wr_addr) == REG_CMD);

	always_comb
	begin
		case (sd_reg_addr_e'(wr_addr))
			REG_ARG, REG_TIMEOUT: wr_err = 1'b0;
			REG_CMD:              wr_err = cmd_blocked;
			default:              wr_err = 1'b1;
		endcase
	end

	always_comb
	begin
		rd_data = 32'd0;
		rd_err  = 1'b0;
		case (sd_reg_addr_e'(s_araddr))
			REG_ARG:      rd_data = arg_q;
			REG_CMD:      rd_data = 32'd0;
			REG_TIMEOUT:  rd_data = timeout_q;
			REG_STATUS:   rd_data = {28'd0, result_q.code, done_q, cmd_blocked};
			REG_RESPONSE: rd_data = result_q.response;
			default:      rd_err = 1'b1;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			aw_got   <= 1'b0;
			w_got    <= 1'b0;
			s_bvalid <= 1'b0;
			s_bresp  <= RESP_OKAY;
		end
		else if (wr_go)
		begin
			aw_got   <= 1'b0;
			w_got    <= 1'b0;
			s_bvalid <= 1'b1;
			s_bresp  <= wr_err ? RESP_SLVERR : RESP_OKAY;
		end
		else
		begin
			if (s_awvalid && s_awready)
				aw_got <= 1'b1;
			if (s_wvalid && s_wready)
				w_got <= 1'b1;
			if (s_bvalid && s_bready)
				s_bvalid <= 1'b0;
		end
	end

	always_ff @(posedge clock)
	begin
		if (s_awvalid && s_awready)
			aw_addr_q <= s_awaddr;
		if (s_wvalid && s_wready)
		begin
			w_data_q <= s_wdata;
			w_strb_q <= s_wstrb;
		end
		// snapshot of the programmed registers for the sequencer
		if (cmd_launch)
		begin
			cmd_req.index          <= wr_data[5:0];
			cmd_req.expect_resp    <= wr_data[8];
			cmd_req.argument       <= arg_q;
			cmd_req.timeout_cycles <= timeout_q;
		end
		if (s_arvalid && s_arready)
			s_rdata <= rd_data;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			arg_q         <= 32'd0;
			timeout_q     <= 32'd0;
			cmd_req_valid <= 1'b0;
		end
		else
		begin
			if (wr_go && !wr_err && sd_reg_addr_e'(wr_addr) == REG_ARG)
				arg_q <= apply_strb(arg_q, wr_data, wr_strb);
			if (wr_go && !wr_err && sd_reg_addr_e'(wr_addr) == REG_TIMEOUT)
				timeout_q <= apply_strb(timeout_q, wr_data, wr_strb);
			if (cmd_launch)
				cmd_req_valid <= 1'b1;
			else if (cmd_req_ready)
				cmd_req_valid <= 1'b0;
		end
	end

	// done and result clear on the next transfer
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			busy_q   <= 1'b0;
			done_q   <= 1'b0;
			result_q <= '{code: RES_OK, response: 32'd0};
		end
		else if (cmd_req_valid && cmd_req_ready)
		begin
			busy_q   <= 1'b1;
			done_q   <= 1'b0;
			result_q <= '{code: RES_OK, response: 32'd0};
		end
		else if (result_valid)
		begin
			busy_q   <= 1'b0;
			done_q   <= 1'b1;
			result_q <= result;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			s_rvalid <= 1'b0;
			s_rresp  <= RESP_OKAY;
		end
		else if (s_arvalid && s_arready)
		begin
			s_rvalid <= 1'b1;
			s_rresp  <= rd_err ? RESP_SLVERR : RESP_OKAY;
		end
		else if (s_rready)
			s_rvalid <= 1'b0;
	end

	assign s_arready = !s_rvalid;

	bvalid_held: assert property (@(posedge clock) disable iff (reset)
		s_bvalid && !s_bready |=> s_bvalid && $stable(s_bresp));

	rvalid_held: assert property (@(posedge clock) disable iff (reset)
		s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata));

endmodule

`default_nettype wire

/* tb.f */
+incdir+.
sd_cmd_pkg.sv
sd_cmd_regs.sv
sd_cmd_controller.sv
sd_cmd_phy.sv
sd_cmd_host.sv
tb_sd_card_model.sv
tb_sd_cmd_host.sv

/* tb_sd_card_model.sv */
`timescale 1ns/100ps
`default_nettype none
`include "sd_cmd_macros.svh"

module tb_sd_card_model (
	input  wire logic  clock,
	input  wire logic  cmd_out,
	input  wire logic  cmd_oe,
	input  wire logic [1:0] mode,
	output logic        drive,
	output logic        drive_bit,
	output logic        seen_start,
	output logic        seen_trans,
	output logic        seen_end,
	output logic [5:0]  seen_index,
	output logic [31:0] seen_arg,
	output logic        seen_crc_ok,
	output int          seen_bits,
	output int          frame_count
);
	localparam logic [1:0] MODE_WRONG_INDEX = 2'd1;
	localparam logic [1:0] MODE_BAD_CRC     = 2'd2;
	localparam logic [1:0] MODE_SILENT      = 2'd3;
	localparam int         REPLY_GAP        = 4;
	localparam logic [31:0] STATUS_MASK     = 32'hA5A50F0F;

	logic [`SD_FRAME_BITS-1:0] shift;
	int                        bits;

	// bitwise crc7 over the 40 bits ahead of the crc field, msb first
	function automatic logic [6:0] crc7(input logic [39:0] body);
		logic [6:0] crc;
		logic       fb;
		crc = 7'd0;
		for (int i = 39; i >= 0; i--)
		begin
			fb  = body[i] ^ crc[6];
			crc = {crc[5:0], 1'b0} ^ (fb ? `SD_CRC7_POLY : 7'd0);
		end
		return crc;
	endfunction

	// R1-style answer, transmission bit low
	task automatic reply(input logic [5:0] index, input logic [31:0] arg);
		logic [`SD_FRAME_BITS-1:0] frame;
		logic [5:0]                idx;
		logic [31:0]               status;
		logic [6:0]                crc;
		idx    = (mode == MODE_WRONG_INDEX) ? index + 6'd1 : index;
		status = arg ^ STATUS_MASK;
		crc    = crc7({2'b00, idx, status});
		if (mode == MODE_BAD_CRC)
			crc = crc ^ 7'h01;
		frame = {2'b00, idx, status, crc, 1'b1};
		repeat (REPLY_GAP) @(negedge clock);
		for (int i = `SD_FRAME_BITS - 1; i >= 0; i--)
		begin
			drive     = 1'b1;
			drive_bit = frame[i];
			@(negedge clock);
		end
		drive     = 1'b0;
		drive_bit = 1'b1;
	endtask

	initial
	begin
		drive       = 1'b0;
		drive_bit   = 1'b1;
		seen_start  = 1'b1;
		seen_trans  = 1'b0;
		seen_end    = 1'b0;
		seen_index  = 6'd0;
		seen_arg    = 32'd0;
		seen_crc_ok = 1'b0;
		seen_bits   = 0;
		frame_count = 0;
		shift       = '0;
		bits        = 0;
		forever
		begin
			@(negedge clock);
			if (cmd_oe)
			begin
				shift = {shift[`SD_FRAME_BITS-2:0], cmd_out};
				bits++;
			end
			else if (bits != 0)
			begin
				seen_start  = shift[47];
				seen_trans  = shift[46];
				seen_index  = shift[45:40];
				seen_arg    = shift[39:8];
				seen_end    = shift[0];
				seen_crc_ok = (crc7(shift[47:8]) == shift[7:1]);
				seen_bits   = bits;
				frame_count++;
				bits = 0;
				if (mode != MODE_SILENT)
					reply(seen_index, seen_arg);
			end
		end
	end

endmodule

`default_nettype wire

/* tb_sd_cmd_host.sv */
`timescale 1ns/100ps
`default_nettype none
`include "sd_cmd_macros.svh"

module tb_sd_cmd_host;
	import sd_cmd_pkg::*;

	// encoding matches the card model's mode input
	typedef enum logic [1:0] {
		CARD_NORMAL,
		CARD_WRONG_INDEX,
		CARD_BAD_CRC,
		CARD_SILENT
	} card_mode_e;

	typedef struct packed {
		logic [5:0]  index;
		logic [31:0] argument;
		logic        expect_resp;
		logic [31:0] timeout;
		card_mode_e  mode;
		logic        busy_write;
		sd_result_e  exp_code;
		logic [31:0] exp_response;
	} cmd_row_t;

	localparam int          NUM_ROWS    = 8;
	localparam logic [1:0]  RESP_OKAY   = 2'b00;
	localparam logic [1:0]  RESP_SLVERR = 2'b10;
	localparam logic [31:0] STATUS_MASK = 32'hA5A50F0F;

	logic                       clock;
	logic                       reset;
	logic [`SD_AXIL_ADDR_W-1:0] s_awaddr;
	logic                       s_awvalid;
	logic                       s_awready;
	logic [31:0]                s_wdata;
	logic [3:0]                 s_wstrb;
	logic                       s_wvalid;
	logic                       s_wready;
	logic [1:0]                 s_bresp;
	logic                       s_bvalid;
	logic                       s_bready;
	logic [`SD_AXIL_ADDR_W-1:0] s_araddr;
	logic                       s_arvalid;
	logic                       s_arready;
	logic [31:0]                s_rdata;
	logic [1:0]                 s_rresp;
	logic                       s_rvalid;
	logic                       s_rready;
	logic                       cmd_out;
	logic                       cmd_oe;
	logic                       cmd_in;
	logic                       card_drive;
	logic                       card_bit;
	card_mode_e                 card_mode;
	logic                       card_start;
	logic                       card_trans;
	logic                       card_end;
	logic [5:0]                 card_index;
	logic [31:0]                card_arg;
	logic                       card_crc_ok;
	int                         card_bits;
	int                         card_frames;

	cmd_row_t    rows [0:NUM_ROWS-1];
	int          row_count;
	logic        rows_loaded;
	logic [31:0] rng_state;
	int          error_count;
	int          test_count;
	int          failed_count;

	// open-drain CMD line
	assign cmd_in = card_drive ? card_bit : (cmd_oe ? cmd_out : 1'b1);

	sd_cmd_host UUT (
		.clock,
		.reset,
		.s_awaddr,
		.s_awvalid,
		.s_awready,
		.s_wdata,
		.s_wstrb,
		.s_wvalid,
		.s_wready,
		.s_bresp,
		.s_bvalid,
		.s_bready,
		.s_araddr,
		.s_arvalid,
		.s_arready,
		.s_rdata,
		.s_rresp,
		.s_rvalid,
		.s_rready,
		.cmd_out,
		.cmd_oe,
		.cmd_in
	);

	tb_sd_card_model card (
		.clock,
		.cmd_out,
		.cmd_oe,
		.mode(card_mode),
		.drive(card_drive),
		.drive_bit(card_bit),
		.seen_start(card_start),
		.seen_trans(card_trans),
		.seen_end(card_end),
		.seen_index(card_index),
		.seen_arg(card_arg),
		.seen_crc_ok(card_crc_ok),
		.seen_bits(card_bits),
		.frame_count(card_frames)
	);

	always #5 clock = ~clock;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic check_result(input string name, input sd_result_e got,
			input sd_result_e expected);
		if (got !== expected)
		begin
			$display("** Error at %0t: %s = %s, expected %s", $time, name,
				got.name(), expected.name());
			error_count++;
		end
	endtask

	task automatic check_word(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected)
		begin
			$display("** Error at %0t: %s = %h, expected %h", $time, name, got, expected);
			error_count++;
		end
	endtask

	task automatic check_resp(input string name, input logic [1:0] got,
			input logic [1:0] expected);
		if (got !== expected)
		begin
			$display("** Error at %0t: %s = %b, expected %b", $time, name, got, expected);
			error_count++;
		end
	endtask

	// ready is sampled on the falling edge, so the handshake lands on the next rise
	task automatic axi_write(input logic [`SD_AXIL_ADDR_W-1:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		logic aw_hit;
		logic w_hit;
		@(negedge clock);
		s_awaddr  = addr;
		s_awvalid = 1'b1;
		s_wdata   = data;
		s_wstrb   = 4'hF;
		s_wvalid  = 1'b1;
		while (s_awvalid || s_wvalid)
		begin
			aw_hit = s_awvalid && s_awready;
			w_hit  = s_wvalid && s_wready;
			@(negedge clock);
			if (aw_hit)
				s_awvalid = 1'b0;
			if (w_hit)
				s_wvalid = 1'b0;
		end
		s_bready = 1'b1;
		while (!s_bvalid)
			@(negedge clock);
		resp = s_bresp;
		@(negedge clock);
		s_bready = 1'b0;
	endtask

	task automatic axi_read(input logic [`SD_AXIL_ADDR_W-1:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		@(negedge clock);
		s_araddr  = addr;
		s_arvalid = 1'b1;
		while (!s_arready)
			@(negedge clock);
		@(negedge clock);
		s_arvalid = 1'b0;
		s_rready  = 1'b1;
		while (!s_rvalid)
			@(negedge clock);
		data = s_rdata;
		resp = s_rresp;
		@(negedge clock);
		s_rready = 1'b0;
	endtask

	task automatic report_test(input string name, input int errors_before);
		test_count++;
		if (error_count == errors_before)
			$display("test %0d %s: passed", test_count, name);
		else
		begin
			failed_count++;
			$display("test %0d %s: failed with %0d errors", test_count, name,
				error_count - errors_before);
		end
	endtask

	// expected outcome follows from the card mode
	task automatic add_row(input logic [5:0] index, input logic expect_resp,
			input logic [31:0] timeout, input card_mode_e mode, input logic busy_write);
		cmd_row_t row;
		rng_state        = xorshift32(rng_state);
		row.index        = index;
		row.argument     = rng_state;
		row.expect_resp  = expect_resp;
		row.timeout      = timeout;
		row.mode         = mode;
		row.busy_write   = busy_write;
		row.exp_code     = RES_OK;
		row.exp_response = 32'd0;
		if (expect_resp)
		begin
			case (mode)
				CARD_NORMAL:      row.exp_response = row.argument ^ STATUS_MASK;
				CARD_WRONG_INDEX: row.exp_code = RES_INDEX_ERR;
				CARD_BAD_CRC:     row.exp_code = RES_CRC_ERR;
				default:          row.exp_code = RES_TIMEOUT;
			endcase
		end
		rows[row_count] = row;
		row_count++;
	endtask

	task automatic check_registers();
		logic [31:0] data;
		logic [1:0]  resp;
		int          errors_before;
		errors_before = error_count;
		axi_read(REG_STATUS, data, resp);
		check_resp("rresp STATUS", resp, RESP_OKAY);
		check_word("STATUS after reset", data, 32'd0);
		axi_write(REG_ARG, 32'h1234_5678, resp);
		check_resp("bresp ARG", resp, RESP_OKAY);
		axi_read(REG_ARG, data, resp);
		check_word("ARG", data, 32'h1234_5678);
		axi_write(REG_TIMEOUT, 32'h0000_0C35, resp);
		check_resp("bresp TIMEOUT", resp, RESP_OKAY);
		axi_read(REG_TIMEOUT, data, resp);
		check_word("TIMEOUT", data, 32'h0000_0C35);
		axi_read(5'h14, data, resp);
		check_resp("rresp unmapped", resp, RESP_SLVERR);
		axi_write(5'h1C, 32'hFFFF_FFFF, resp);
		check_resp("bresp unmapped", resp, RESP_SLVERR);
		axi_write(REG_STATUS, 32'h0000_000F, resp);
		check_resp("bresp STATUS", resp, RESP_SLVERR);
		axi_read(REG_STATUS, data, resp);
		check_word("STATUS after write", data, 32'd0);
		report_test("register access", errors_before);
	endtask

	task automatic run_row(input int n);
		cmd_row_t    row;
		logic [31:0] cmd_word;
		logic [31:0] data;
		logic [1:0]  resp;
		int          errors_before;
		int          frames_before;
		row           = rows[n];
		errors_before = error_count;
		frames_before = card_frames;
		card_mode     = row.mode;
		cmd_word      = {23'd0, row.expect_resp, 2'b00, row.index};
		axi_write(REG_ARG, row.argument, resp);
		check_resp("bresp ARG", resp, RESP_OKAY);
		axi_write(REG_TIMEOUT, row.timeout, resp);
		check_resp("bresp TIMEOUT", resp, RESP_OKAY);
		axi_write(REG_CMD, cmd_word, resp);
		check_resp("bresp CMD", resp, RESP_OKAY);
		if (row.busy_write)
		begin
			axi_write(REG_CMD, cmd_word ^ 32'h0000_0015, resp);
			check_resp("bresp CMD while busy", resp, RESP_SLVERR);
		end
		do
			axi_read(REG_STATUS, data, resp);
		while (data[0]);
		check_word("STATUS", data, {28'd0, row.exp_code, 2'b10});
		check_result("STATUS.result", sd_result_e'(data[3:2]), row.exp_code);
		axi_read(REG_RESPONSE, data, resp);
		check_resp("rresp RESPONSE", resp, RESP_OKAY);
		check_word("RESPONSE", data, row.exp_response);
		// frame as the card saw it
		check_word("card frame count", card_frames, frames_before + 1);
		check_word("frame length", card_bits, 48);
		check_word("frame start bit", {31'd0, card_start}, 32'd0);
		check_word("frame transmission bit", {31'd0, card_trans}, 32'd1);
		check_word("frame end bit", {31'd0, card_end}, 32'd1);
		check_word("frame crc7 match", {31'd0, card_crc_ok}, 32'd1);
		check_word("frame index", {26'd0, card_index}, {26'd0, row.index});
		check_word("frame argument", card_arg, row.argument);
		report_test($sformatf("row %0d CMD%0d %s", n, row.index, card_mode.name()),
			errors_before);
	endtask

	initial
	begin
		int limit;
		wait (rows_loaded);
		limit = 500;
		for (int i = 0; i < row_count; i++)
			limit = limit + int'(rows[i].timeout) + 200;
		repeat (limit) @(posedge clock);
		$display("watchdog expired after %0d cycles with the run still going", limit);
		$display("Finished with errors");
		$finish;
	end

	initial
	begin
		clock        = 1'b0;
		reset        = 1'b1;
		s_awaddr     = '0;
		s_awvalid    = 1'b0;
		s_wdata      = 32'd0;
		s_wstrb      = 4'h0;
		s_wvalid     = 1'b0;
		s_bready     = 1'b0;
		s_araddr     = '0;
		s_arvalid    = 1'b0;
		s_rready     = 1'b0;
		card_mode    = CARD_SILENT;
		error_count  = 0;
		test_count   = 0;
		failed_count = 0;
		row_count    = 0;
		rng_state    = 32'h46153129;
		rows_loaded  = 1'b0;
		add_row(6'd17, 1'b1, 32'd64, CARD_NORMAL, 1'b0);
		add_row(6'd55, 1'b1, 32'd64, CARD_NORMAL, 1'b0);
		add_row(6'd8, 1'b1, 32'd64, CARD_WRONG_INDEX, 1'b0);
		add_row(6'd24, 1'b1, 32'd64, CARD_BAD_CRC, 1'b0);
		add_row(6'd41, 1'b1, 32'd30, CARD_SILENT, 1'b0);
		add_row(6'd0, 1'b0, 32'd64, CARD_SILENT, 1'b0);
		add_row(6'd12, 1'b1, 32'd64, CARD_NORMAL, 1'b1);
		add_row(6'd63, 1'b1, 32'd64, CARD_WRONG_INDEX, 1'b1);
		rows_loaded = 1'b1;
		repeat (2) @(negedge clock);
		reset = 1'b0;
		check_registers();
		for (int n = 0; n < row_count; n++)
			run_row(n);
		$display("tests run: %0d, tests failed: %0d, errors: %0d", test_count,
			failed_count, error_count);
		if (error_count == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire
